// File: src/exu_pkg.sv
package exu_pkg;

    // alu operation select, code 4'd2 is unused
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_xor = 4'd5,
        alu_cmp = 4'd6,  // set less than
        alu_ne  = 4'd7,  // 1 when operands differ
        alu_sll = 4'd8,
        alu_srl = 4'd9,
        alu_sra = 4'd10
    } alu_op_e;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    localparam logic [2:0] f3_add  = 3'b000;  // add/sub/addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;  // srl/sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // imm_hi and rs2 together form the i-type immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_b_t b;
    } instr_u;

endpackage

// File: src/exu_adder.sv
`timescale 1ns/1ps

module exu_adder #(
    parameter int XLEN = 32
) (
    input  logic            sub,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] sum,
    output logic            ovf
);

    logic [XLEN-1:0] b_eff;

    assign b_eff = sub ? ~b : b;  // two's complement via carry in
    assign sum   = a + b_eff + {{(XLEN-1){1'b0}}, sub};

    // same input signs, different result sign
    assign ovf = (a[XLEN-1] == b_eff[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);

endmodule

// File: src/exu_alu.sv
`timescale 1ns/1ps

module exu_alu #(
    parameter int XLEN = 32
) (
    input  exu_pkg::alu_op_e alu_op,
    input  logic             comp_unsigned,
    input  logic [XLEN-1:0]  d1,
    input  logic [XLEN-1:0]  d2,
    output logic [XLEN-1:0]  res,
    output logic             ovf
);

    localparam int SHW = $clog2(XLEN);

    logic            sub;
    logic [XLEN-1:0] sum;
    logic            add_ovf;
    logic [SHW-1:0]  shamt;
    logic            lt;

    assign shamt = d2[SHW-1:0];

    always_comb begin
        sub = 1'b0;
        ovf = 1'b0;
        lt  = 1'b0;
        res = '0;
        case (alu_op)
            exu_pkg::alu_add: begin
                res = sum;
                ovf = add_ovf;
            end
            exu_pkg::alu_sub: begin
                sub = 1'b1;
                res = sum;
                ovf = add_ovf;
            end
            exu_pkg::alu_and: begin
                res = d1 & d2;
            end
            exu_pkg::alu_or: begin
                res = d1 | d2;
            end
            exu_pkg::alu_xor: begin
                res = d1 ^ d2;
            end
            exu_pkg::alu_cmp: begin
                sub = 1'b1;
                if (comp_unsigned) begin
                    lt = (d1 < d2);
                end else if (d1[XLEN-1] != d2[XLEN-1]) begin
                    lt = d1[XLEN-1];  // negative one is smaller
                end else begin
                    lt = sum[XLEN-1];  // sign of difference
                end
                res = {{(XLEN-1){1'b0}}, lt};
            end
            exu_pkg::alu_ne: begin
                sub = 1'b1;
                res = {{(XLEN-1){1'b0}}, (sum != '0)};
            end
            exu_pkg::alu_sll: begin
                res = d1 << shamt;
            end
            exu_pkg::alu_srl: begin
                res = d1 >> shamt;
            end
            exu_pkg::alu_sra: begin
                res = $signed(d1) >>> shamt;
            end
            default: begin
                res = '0;
            end
        endcase
    end

    exu_adder #(
        .XLEN (XLEN)
    ) i_adder (
        .sub  (sub),
        .a    (d1),
        .b    (d2),
        .sum  (sum),
        .ovf  (add_ovf)
    );

endmodule

// File: src/exu_decoder.sv
`timescale 1ns/1ps

module exu_decoder #(
    parameter int XLEN = 32
) (
    input  exu_pkg::instr_u  instr,
    input  logic [XLEN-1:0]  rs2_val,
    output exu_pkg::alu_op_e alu_op,
    output logic             comp_unsigned,
    output logic [XLEN-1:0]  operand_b,
    output logic [XLEN-1:0]  imm,
    output logic             is_branch,
    output logic [2:0]       br_funct3,
    output logic [4:0]       rd,
    output logic             wr_en
);

    logic            use_imm;
    logic            alt;  // funct7 bit 30
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;

    assign alt   = instr.r.funct7[5];
    assign imm_i = {{(XLEN-12){instr.b.imm_hi[6]}}, instr.b.imm_hi, instr.b.rs2};
    assign imm_b = {{(XLEN-12){instr.b.imm_hi[6]}}, instr.b.imm_lo[0],
                    instr.b.imm_hi[5:0], instr.b.imm_lo[4:1], 1'b0};

    assign rd        = instr.r.rd;
    assign br_funct3 = instr.r.funct3;
    assign operand_b = use_imm ? imm : rs2_val;

    always_comb begin
        alu_op        = exu_pkg::alu_add;
        comp_unsigned = 1'b0;
        use_imm       = 1'b0;
        imm           = '0;
        is_branch     = 1'b0;
        wr_en         = 1'b0;
        case (instr.r.opcode)
            exu_pkg::opc_op, exu_pkg::opc_op_imm: begin
                wr_en   = 1'b1;
                use_imm = (instr.r.opcode == exu_pkg::opc_op_imm);
                imm     = imm_i;
                case (instr.r.funct3)
                    exu_pkg::f3_add:  alu_op = (alt && !use_imm) ? exu_pkg::alu_sub
                                                                 : exu_pkg::alu_add;
                    exu_pkg::f3_sll:  alu_op = exu_pkg::alu_sll;
                    exu_pkg::f3_slt:  alu_op = exu_pkg::alu_cmp;
                    exu_pkg::f3_sltu: begin
                        alu_op        = exu_pkg::alu_cmp;
                        comp_unsigned = 1'b1;
                    end
                    exu_pkg::f3_xor:  alu_op = exu_pkg::alu_xor;
                    exu_pkg::f3_srl:  alu_op = alt ? exu_pkg::alu_sra : exu_pkg::alu_srl;
                    exu_pkg::f3_or:   alu_op = exu_pkg::alu_or;
                    default:          alu_op = exu_pkg::alu_and;
                endcase
            end
            exu_pkg::opc_branch: begin
                is_branch = 1'b1;
                imm       = imm_b;  // compare still uses rs2
                case (instr.r.funct3)
                    exu_pkg::f3_beq, exu_pkg::f3_bne: alu_op = exu_pkg::alu_ne;
                    exu_pkg::f3_blt, exu_pkg::f3_bge: alu_op = exu_pkg::alu_cmp;
                    default: begin
                        alu_op        = exu_pkg::alu_cmp;
                        comp_unsigned = 1'b1;
                    end
                endcase
            end
            default: begin
                alu_op = exu_pkg::alu_add;  // result ignored, no write
            end
        endcase
    end

endmodule

// File: src/exu_commit.sv
`timescale 1ns/1ps

module exu_commit #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_in,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    input  logic            is_branch,
    input  logic [2:0]      br_funct3,
    input  logic [4:0]      rd,
    input  logic            wr_en,
    input  logic [XLEN-1:0] alu_res,
    input  logic            alu_ovf,
    output logic            valid_out,
    output logic [XLEN-1:0] result,
    output logic            overflow,
    output logic [4:0]      rd_out,
    output logic            wr_en_out,
    output logic            branch_taken,
    output logic [XLEN-1:0] next_pc
);

    logic            invert;
    logic            taken;
    logic [XLEN-1:0] target;

    // beq, bge, bgeu test the opposite of the alu bit
    assign invert = (br_funct3 == exu_pkg::f3_beq) ||
                    (br_funct3 == exu_pkg::f3_bge) ||
                    (br_funct3 == exu_pkg::f3_bgeu);
    assign taken  = is_branch && (alu_res[0] ^ invert);
    assign target = taken ? (pc + imm) : (pc + XLEN'(4));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out    <= 1'b0;
            result       <= '0;
            overflow     <= 1'b0;
            rd_out       <= '0;
            wr_en_out    <= 1'b0;
            branch_taken <= 1'b0;
            next_pc      <= '0;
        end else begin
            valid_out <= valid_in;  // one cycle pulse
            if (valid_in) begin
                result       <= alu_res;
                overflow     <= alu_ovf;
                rd_out       <= rd;
                wr_en_out    <= wr_en;
                branch_taken <= taken;
                next_pc      <= target;
            end
        end
    end

endmodule

// File: src/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_in,
    input  logic [31:0]     instr,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    output logic            valid_out,
    output logic [XLEN-1:0] result,
    output logic            overflow,
    output logic [4:0]      rd_out,
    output logic            wr_en_out,
    output logic            branch_taken,
    output logic [XLEN-1:0] next_pc
);

    exu_pkg::alu_op_e alu_op;
    logic             comp_unsigned;
    logic [XLEN-1:0]  operand_b;
    logic [XLEN-1:0]  imm;
    logic             is_branch;
    logic [2:0]       br_funct3;
    logic [4:0]       rd;
    logic             wr_en;
    logic [XLEN-1:0]  alu_res;
    logic             alu_ovf;

    exu_decoder #(.XLEN(XLEN)) i_decoder (
        .instr         (instr),
        .rs2_val       (rs2_val),
        .alu_op        (alu_op),
        .comp_unsigned (comp_unsigned),
        .operand_b     (operand_b),
        .imm           (imm),
        .is_branch     (is_branch),
        .br_funct3     (br_funct3),
        .rd            (rd),
        .wr_en         (wr_en)
    );

    exu_alu #(.XLEN(XLEN)) i_alu (
        .alu_op        (alu_op),
        .comp_unsigned (comp_unsigned),
        .d1            (rs1_val),
        .d2            (operand_b),
        .res           (alu_res),
        .ovf           (alu_ovf)
    );

    exu_commit #(.XLEN(XLEN)) i_commit (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .pc            (pc),
        .imm           (imm),
        .is_branch     (is_branch),
        .br_funct3     (br_funct3),
        .rd            (rd),
        .wr_en         (wr_en),
        .alu_res       (alu_res),
        .alu_ovf       (alu_ovf),
        .valid_out     (valid_out),
        .result        (result),
        .overflow      (overflow),
        .rd_out        (rd_out),
        .wr_en_out     (wr_en_out),
        .branch_taken  (branch_taken),
        .next_pc       (next_pc)
    );

endmodule

// File: tb/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

    logic        clk;
    logic        rst_n;
    logic        valid_in;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        valid_out;
    logic [31:0] result;
    logic        overflow;
    logic [4:0]  rd_out;
    logic        wr_en_out;
    logic        branch_taken;
    logic [31:0] next_pc;

    logic [31:0] rng_state = 32'd80326;
    logic [71:0] exp_q[$];  // {rd, wr, taken, ovf, next_pc, result}
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;

    exu_top #(.XLEN(32)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .instr        (instr),
        .pc           (pc),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .valid_out    (valid_out),
        .result       (result),
        .overflow     (overflow),
        .rd_out       (rd_out),
        .wr_en_out    (wr_en_out),
        .branch_taken (branch_taken),
        .next_pc      (next_pc)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        logic [31:0] r;
        r = xorshift32();
        return {f7, 5'd2, 5'd1, f3, r[4:0], exu_pkg::opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3);
        logic [31:0] r;
        r = xorshift32();
        return {imm, 5'd1, f3, r[4:0], exu_pkg::opc_op_imm};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], exu_pkg::opc_branch};
    endfunction

    // expected outcome from the RV32I rules
    function automatic logic [71:0] model(input logic [31:0] ins, pc_v, a, b);
        logic [31:0] bo;
        logic [31:0] res;
        logic [31:0] imm_b;
        logic [32:0] wide;
        logic        ovf;
        logic        taken;
        logic        wr;
        logic        is_reg;
        logic [2:0]  f3;
        f3     = ins[14:12];
        is_reg = (ins[6:0] == exu_pkg::opc_op);
        imm_b  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        bo     = is_reg ? b : {{20{ins[31]}}, ins[31:20]};
        res    = '0;
        ovf    = 1'b0;
        taken  = 1'b0;
        wr     = is_reg || (ins[6:0] == exu_pkg::opc_op_imm);
        if (wr) begin
            case (f3)
                3'b000: begin
                    if (is_reg && ins[30]) wide = {a[31], a} - {bo[31], bo};
                    else wide = {a[31], a} + {bo[31], bo};
                    res = wide[31:0];
                    ovf = wide[32] ^ wide[31];
                end
                3'b001: res = a << bo[4:0];
                3'b010: res = ($signed(a) < $signed(bo)) ? 32'd1 : 32'd0;
                3'b011: res = (a < bo) ? 32'd1 : 32'd0;
                3'b100: res = a ^ bo;
                3'b101: begin
                    if (ins[30]) res = $signed(a) >>> bo[4:0];
                    else res = a >> bo[4:0];
                end
                3'b110: res = a | bo;
                default: res = a & bo;
            endcase
        end else if (ins[6:0] == exu_pkg::opc_branch) begin
            case (f3)
                3'b000: taken = (a == b);
                3'b001: taken = (a != b);
                3'b100: taken = ($signed(a) < $signed(b));
                3'b101: taken = ($signed(a) >= $signed(b));
                3'b110: taken = (a < b);
                default: taken = (a >= b);
            endcase
        end
        return {ins[11:7], wr, taken, ovf, taken ? pc_v + imm_b : pc_v + 32'd4, res};
    endfunction

    task automatic check_value(input logic [31:0] got, want, input string what);
        assert (got === want) else begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    // caller is at a falling edge
    task automatic drive(input logic [31:0] ins, pc_v, a, b);
        instr    = ins;
        pc       = pc_v;
        rs1_val  = a;
        rs2_val  = b;
        valid_in = 1'b1;
        exp_q.push_back(model(ins, pc_v, a, b));
    endtask

    task automatic wait_and_check();
        logic [71:0] e;
        int          n;
        n = 0;
        while (!valid_out && n < 20) begin
            @(negedge clk);
            n++;
        end
        e = exp_q.pop_front();
        if (!valid_out) begin
            $display("timeout at %0t: valid_out never rose within 20 cycles", $time);
            errors++;
        end else begin
            check_value(n, 0, "extra cycles before valid_out");
            check_value(wr_en_out, e[66], "wr_en_out");
            check_value(branch_taken, e[65], "branch_taken");
            check_value(next_pc, e[63:32], "next_pc");
            if (e[66]) begin
                check_value(result, e[31:0], "result");
                check_value(overflow, e[64], "overflow");
                check_value(rd_out, e[71:67], "rd_out");
            end
        end
    endtask

    task automatic run_one(input logic [31:0] ins, pc_v, a, b);
        @(negedge clk);
        drive(ins, pc_v, a, b);
        @(negedge clk);
        valid_in = 1'b0;
        wait_and_check();
        @(negedge clk);
        check_value(valid_out, 0, "valid_out after pulse");
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        if (errors != start) failed_tests++;
        $display("%s: %0d errors", name, errors - start);
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        check_value(valid_out, 0, "valid_out after reset");
        check_value(wr_en_out, 0, "wr_en_out after reset");
        check_value(branch_taken, 0, "branch_taken after reset");
        check_value(result, 0, "result after reset");
        check_value(overflow, 0, "overflow after reset");
        check_value(rd_out, 0, "rd_out after reset");
        check_value(next_pc, 0, "next_pc after reset");
        finish_test("reset", start);
    endtask

    task automatic test_r_type();
        logic [2:0] f3s [7] = '{exu_pkg::f3_add, exu_pkg::f3_add, exu_pkg::f3_and,
                               exu_pkg::f3_or, exu_pkg::f3_xor, exu_pkg::f3_slt,
                               exu_pkg::f3_sltu};
        int start;
        start = errors;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 7; i++) begin
                run_one(enc_r((i == 1) ? 7'h20 : 7'h00, f3s[i]), 32'h1000,
                        xorshift32(), xorshift32());
            end
        end
        run_one(enc_r(7'h00, exu_pkg::f3_add), 32'h1000, 32'h7fff_ffff, 32'd1);
        run_one(enc_r(7'h20, exu_pkg::f3_add), 32'h1000, 32'h8000_0000, 32'd1);
        finish_test("r_type", start);
    endtask

    task automatic test_i_type();
        logic [2:0]  f3s [6] = '{exu_pkg::f3_add, exu_pkg::f3_slt, exu_pkg::f3_sltu,
                                exu_pkg::f3_xor, exu_pkg::f3_or, exu_pkg::f3_and};
        logic [31:0] r;
        int          start;
        start = errors;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 6; i++) begin
                r = xorshift32();
                run_one(enc_i(r[11:0], f3s[i]), 32'h2000, xorshift32(), 32'd0);
            end
            r = xorshift32();
            run_one(enc_i({7'h00, r[4:0]}, exu_pkg::f3_sll), 32'h2000, xorshift32(), 32'd0);
            run_one(enc_i({7'h00, r[9:5]}, exu_pkg::f3_srl), 32'h2000, xorshift32(), 32'd0);
            run_one(enc_i({7'h20, r[14:10]}, exu_pkg::f3_srl), 32'h2000, xorshift32(), 0);
            // register shifts with junk in the upper amount bits
            run_one(enc_r(7'h00, exu_pkg::f3_sll), 32'h2000, xorshift32(), xorshift32());
            run_one(enc_r(7'h20, exu_pkg::f3_srl), 32'h2000, xorshift32(), xorshift32());
        end
        finish_test("i_type", start);
    endtask

    task automatic test_branches();
        logic [2:0]  f3s [6] = '{exu_pkg::f3_beq, exu_pkg::f3_bne, exu_pkg::f3_blt,
                                exu_pkg::f3_bge, exu_pkg::f3_bltu, exu_pkg::f3_bgeu};
        logic [31:0] xs [4] = '{32'h1234, 32'hffff_fffb, 32'd3, 32'd2};
        logic [31:0] ys [4] = '{32'h1234, 32'd3, 32'hffff_fffb, 32'd9};
        logic [31:0] r;
        int          start;
        start = errors;
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 4; j++) begin
                r = xorshift32();
                run_one(enc_b({r[12:1], 1'b0}, f3s[i]), {r[31:14], 14'h0}, xs[j], ys[j]);
            end
        end
        finish_test("branches", start);
    endtask

    task automatic test_back_to_back();
        int start;
        start = errors;
        @(negedge clk);
        drive(enc_r(7'h00, exu_pkg::f3_add), 32'h300, xorshift32(), xorshift32());
        @(negedge clk);
        drive(enc_i(12'hf80, exu_pkg::f3_xor), 32'h304, xorshift32(), 32'd0);
        wait_and_check();
        @(negedge clk);
        drive(enc_b(13'h1ff0, exu_pkg::f3_bne), 32'h308, 32'd5, 32'd6);
        wait_and_check();
        @(negedge clk);
        drive(enc_r(7'h20, exu_pkg::f3_add), 32'h30c, xorshift32(), xorshift32());
        wait_and_check();
        @(negedge clk);
        valid_in = 1'b0;
        wait_and_check();
        finish_test("back_to_back", start);
    endtask

    task automatic test_unknown_opcode();
        int start;
        start = errors;
        run_one({25'h1abcdef, 7'b0000011}, 32'h4000, xorshift32(), xorshift32());
        run_one({25'h0123456, 7'b1101111}, 32'h4100, xorshift32(), xorshift32());
        finish_test("unknown_opcode", start);
    endtask

    initial begin
        rst_n    = 1'b0;
        valid_in = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1_val  = '0;
        rs2_val  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_r_type();
        test_i_type();
        test_branches();
        test_back_to_back();
        test_unknown_opcode();
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/exu_pkg.sv
src/exu_adder.sv
src/exu_alu.sv
src/exu_decoder.sv
src/exu_commit.sv
src/exu_top.sv
tb/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - src/exu_pkg.sv
  - src/exu_adder.sv
  - src/exu_alu.sv
  - src/exu_decoder.sv
  - src/exu_commit.sv
  - src/exu_top.sv
  - target: test
    files:
      - tb/exu_tb.sv
